/* verilog/demosaic_macros.svh */
`ifndef DEMOSAIC_MACROS_SVH
`define DEMOSAIC_MACROS_SVH

// Frame geometry, both dimensions even
`define FRAME_WIDTH 16
`define FRAME_HEIGHT 8

// Two trailing zero rows flush the row memories
`define FRAME_STROBES ((`FRAME_HEIGHT + 2) * `FRAME_WIDTH)

// Strobe index at which raster pixel 0 sits in the window centre
`define CENTER_LAG (`FRAME_WIDTH + 1)

// Strobes from window centre to output register
`define INTERP_DEPTH 4

// Mean activity per non-green pixel
`define ACT_LEVEL1 4
`define ACT_LEVEL2 8
`define ACT_LEVEL3 16
`define ACT_LEVEL4 32

// Edge thresholds, quiet frames first
`define THRESH_0 50
`define THRESH_1 40
`define THRESH_2 20
`define THRESH_3 15
`define THRESH_4 8

`endif

/* verilog/demosaic_pkg.sv */
`default_nettype none

package demosaic_pkg;

	// One sensor sample or colour channel
	typedef logic [7:0] pixel_t;

	// Column or row index
	typedef logic [15:0] coord_t;

	// Holds h + v with both at full scale
	typedef logic [8:0] grad_t;

	typedef logic [31:0] activity_t;

	// Where the tracker is within a frame
	typedef enum logic [1:0] {
		phaseFilling,
		phaseStreaming,
		phaseDraining
	} trackPhase_t;

endpackage

`default_nettype wire

/* verilog/abs_diff.sv */
`timescale 1ns/10ps
`default_nettype none

module abs_diff import demosaic_pkg::*; #(
	parameter int extraStages = 1
) (
	input wire clk,
	input wire reset,
	input wire strobe,
	input wire pixel_t a,
	input wire pixel_t b,
	output pixel_t result
);

	// Top bit of each difference is the borrow
	grad_t aMinusB;
	grad_t bMinusA;
	pixel_t delayLine [extraStages];

	always_ff @(posedge clk) begin
		if (reset) begin
			aMinusB <= '0;
			bMinusA <= '0;
		end else if (strobe) begin
			aMinusB <= grad_t'(a) - grad_t'(b);
			bMinusA <= grad_t'(b) - grad_t'(a);
		end
	end

	// Keep whichever difference did not borrow
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < extraStages; i++) begin
				delayLine[i] <= '0;
			end
		end else if (strobe) begin
			delayLine[0] <= aMinusB[8] ? bMinusA[7:0] : aMinusB[7:0];
			for (int i = 1; i < extraStages; i++) begin
				delayLine[i] <= delayLine[i-1];
			end
		end
	end

	assign result = delayLine[extraStages-1];

endmodule

`default_nettype wire

/* verilog/bayer_line_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "demosaic_macros.svh"

module bayer_line_buffer import demosaic_pkg::*; (
	input wire clk,
	input wire reset,
	input wire strobe,
	input wire pixel_t data,
	output pixel_t window00,
	output pixel_t window01,
	output pixel_t window02,
	output pixel_t window10,
	output pixel_t window11,
	output pixel_t window12,
	output pixel_t window20,
	output pixel_t window21,
	output pixel_t window22
);

	localparam int ptrBits = $clog2(`FRAME_WIDTH);
	localparam logic [ptrBits-1:0] lastPtr = ptrBits'(`FRAME_WIDTH - 1);

	logic [ptrBits-1:0] wrPtr;
	pixel_t row1Mem [`FRAME_WIDTH];
	pixel_t row0Mem [`FRAME_WIDTH];
	pixel_t rowIn [3];
	pixel_t win [3][3];

	// Row 2 is the live input, row 0 is two rows old
	assign rowIn[2] = data;
	assign rowIn[1] = row1Mem[wrPtr];
	assign rowIn[0] = row0Mem[wrPtr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
		end else if (strobe) begin
			wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
		end
	end

	// Second memory takes what falls out of the first
	always_ff @(posedge clk) begin
		if (strobe) begin
			row1Mem[wrPtr] <= data;
			row0Mem[wrPtr] <= rowIn[1];
		end
	end

	// Column 2 is the newest sample, so column 0 is the left neighbour
	always_ff @(posedge clk) begin
		if (strobe) begin
			for (int r = 0; r < 3; r++) begin
				win[r][2] <= rowIn[r];
				win[r][1] <= win[r][2];
				win[r][0] <= win[r][1];
			end
		end
	end

	assign window00 = win[0][0];
	assign window01 = win[0][1];
	assign window02 = win[0][2];
	assign window10 = win[1][0];
	assign window11 = win[1][1];
	assign window12 = win[1][2];
	assign window20 = win[2][0];
	assign window21 = win[2][1];
	assign window22 = win[2][2];

	wrPtrInRange: assert property (@(posedge clk) disable iff (reset)
		int'(wrPtr) < `FRAME_WIDTH)
		else $error("line buffer write pointer out of range: %0d", wrPtr);

endmodule

`default_nettype wire

/* verilog/raster_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "demosaic_macros.svh"

module raster_tracker import demosaic_pkg::*; (
	input wire clk,
	input wire reset,
	input wire strobe,
	output coord_t centerX,
	output coord_t centerY,
	output logic centerValid,
	output logic frameEnd
);

	localparam int countBits = $clog2(`FRAME_STROBES);

	typedef logic [countBits-1:0] count_t;

	localparam count_t fillEnd = count_t'(`CENTER_LAG - 1);
	localparam count_t streamEnd = count_t'(`CENTER_LAG + `FRAME_WIDTH * `FRAME_HEIGHT - 1);
	localparam count_t lastStrobe = count_t'(`FRAME_STROBES - 1);
	localparam coord_t lastCol = coord_t'(`FRAME_WIDTH - 1);
	localparam coord_t lastRow = coord_t'(`FRAME_HEIGHT - 1);

	count_t strobeCount;
	trackPhase_t phase;
	trackPhase_t nextPhase;

	always_ff @(posedge clk) begin
		if (reset) begin
			strobeCount <= '0;
		end else if (strobe) begin
			strobeCount <= (strobeCount == lastStrobe) ? '0 : strobeCount + 1'b1;
		end
	end

	// Phase always describes the strobe index held in strobeCount
	always_comb begin
		nextPhase = phase;
		case (phase)
			phaseFilling: if (strobeCount == fillEnd) nextPhase = phaseStreaming;
			phaseStreaming: if (strobeCount == streamEnd) nextPhase = phaseDraining;
			phaseDraining: if (strobeCount == lastStrobe) nextPhase = phaseFilling;
			default: nextPhase = phaseFilling;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= phaseFilling;
		end else if (strobe) begin
			phase <= nextPhase;
		end
	end

	// Centre position steps once per streaming strobe, restarting each frame
	always_ff @(posedge clk) begin
		if (reset) begin
			centerX <= '0;
			centerY <= '0;
			centerValid <= 1'b0;
		end else if (strobe) begin
			centerValid <= (phase == phaseStreaming);
			if (phase == phaseStreaming) begin
				if (!centerValid) begin
					centerX <= '0;
					centerY <= '0;
				end else if (centerX == lastCol) begin
					centerX <= '0;
					centerY <= (centerY == lastRow) ? '0 : centerY + 1'b1;
				end else begin
					centerX <= centerX + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			frameEnd <= 1'b0;
		end else begin
			frameEnd <= strobe && (strobeCount == lastStrobe);
		end
	end

	centerXInFrame: assert property (@(posedge clk) disable iff (reset)
		centerValid |-> int'(centerX) < `FRAME_WIDTH)
		else $error("centre column %0d outside frame", centerX);

endmodule

`default_nettype wire

/* verilog/green_interpolator.sv */
`timescale 1ns/10ps
`default_nettype none

`include "demosaic_macros.svh"

module green_interpolator import demosaic_pkg::*; (
	input wire clk,
	input wire reset,
	input wire strobe,
	input wire pixel_t window00,
	input wire pixel_t window01,
	input wire pixel_t window02,
	input wire pixel_t window10,
	input wire pixel_t window11,
	input wire pixel_t window12,
	input wire pixel_t window20,
	input wire pixel_t window21,
	input wire pixel_t window22,
	input wire coord_t centerX,
	input wire coord_t centerY,
	input wire centerValid,
	output pixel_t red,
	output pixel_t green,
	output pixel_t blue,
	output coord_t pixelX,
	output coord_t pixelY,
	output logic pixelValid,
	output grad_t gradSum,
	output logic gradSumValid
);

	localparam coord_t lastCol = coord_t'(`FRAME_WIDTH - 1);
	localparam coord_t lastRow = coord_t'(`FRAME_HEIGHT - 1);

	function automatic pixel_t avg2(input pixel_t p, input pixel_t q);
		grad_t total;
		total = grad_t'(p) + grad_t'(q);
		return total[8:1];
	endfunction

	// Corner taps only matter for red and blue interpolation
	pixel_t maskLeft, maskRight, maskUp, maskDown;
	pixel_t hAvgIn, vAvgIn;
	pixel_t left1, right1, up1, down1;
	pixel_t hAvg1, vAvg1, hAvg2, vAvg2, hAvg3, vAvg3, hvMean3;
	pixel_t center1, center2, center3;
	coord_t x1, x2, x3, y1, y2, y3;
	logic valid1, valid2, valid3;
	pixel_t hGrad, vGrad, greenSel;

	// Neighbours outside the frame read as zero
	always_comb begin
		maskLeft = (centerX == '0) ? '0 : window10;
		maskRight = (centerX == lastCol) ? '0 : window12;
		maskUp = (centerY == '0) ? '0 : window01;
		maskDown = (centerY == lastRow) ? '0 : window21;
		if (centerX == '0) hAvgIn = maskRight;
		else if (centerX == lastCol) hAvgIn = maskLeft;
		else hAvgIn = avg2(maskLeft, maskRight);
		if (centerY == '0) vAvgIn = maskDown;
		else if (centerY == lastRow) vAvgIn = maskUp;
		else vAvgIn = avg2(maskUp, maskDown);
	end

	always_ff @(posedge clk) begin
		if (strobe) begin
			left1 <= maskLeft;
			right1 <= maskRight;
			up1 <= maskUp;
			down1 <= maskDown;
			hAvg1 <= hAvgIn;
			vAvg1 <= vAvgIn;
			center1 <= window11;
			x1 <= centerX;
			y1 <= centerY;
			// Stages 2 and 3 cover the gradient latency
			hAvg2 <= hAvg1;
			vAvg2 <= vAvg1;
			center2 <= center1;
			x2 <= x1;
			y2 <= y1;
			hAvg3 <= hAvg2;
			vAvg3 <= vAvg2;
			hvMean3 <= avg2(hAvg2, vAvg2);
			center3 <= center2;
			x3 <= x2;
			y3 <= y2;
		end
	end

	abs_diff #(.extraStages(1)) hGradient (
		.clk(clk),
		.reset(reset),
		.strobe(strobe),
		.a(left1),
		.b(right1),
		.result(hGrad)
	);

	abs_diff #(.extraStages(1)) vGradient (
		.clk(clk),
		.reset(reset),
		.strobe(strobe),
		.a(up1),
		.b(down1),
		.result(vGrad)
	);

	// Interpolate along the flatter direction
	always_comb begin
		if (hGrad > vGrad) greenSel = vAvg3;
		else if (hGrad < vGrad) greenSel = hAvg3;
		else greenSel = hvMean3;
	end

	always_ff @(posedge clk) begin
		if (strobe) begin
			pixelX <= x3;
			pixelY <= y3;
			gradSum <= grad_t'(hGrad) + grad_t'(vGrad);
			case ({y3[0], x3[0]})
				2'b01: begin
					// Blue site
					red <= '0;
					green <= greenSel;
					blue <= center3;
				end
				2'b10: begin
					// Red site
					red <= center3;
					green <= greenSel;
					blue <= '0;
				end
				default: begin
					red <= '0;
					green <= center3;
					blue <= '0;
				end
			endcase
		end
	end

	// gradSumValid is held until the next strobe, pixelValid is a pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			valid3 <= 1'b0;
			pixelValid <= 1'b0;
			gradSumValid <= 1'b0;
		end else begin
			pixelValid <= strobe && valid3;
			if (strobe) begin
				valid1 <= centerValid;
				valid2 <= valid1;
				valid3 <= valid2;
				gradSumValid <= valid3 && (x3[0] ^ y3[0]);
			end
		end
	end

	pixelInFrame: assert property (@(posedge clk) disable iff (reset)
		pixelValid |-> int'(pixelX) < `FRAME_WIDTH && int'(pixelY) < `FRAME_HEIGHT)
		else $error("output pixel (%0d,%0d) outside frame", pixelX, pixelY);

endmodule

`default_nettype wire

/* verilog/activity_threshold.sv */
`timescale 1ns/10ps
`default_nettype none

`include "demosaic_macros.svh"

module activity_threshold import demosaic_pkg::*; (
	input wire clk,
	input wire reset,
	input wire strobe,
	input wire grad_t gradSum,
	input wire gradSumValid,
	input wire frameEnd,
	output pixel_t threshold,
	output logic frameDone
);

	// Levels scaled by the non-green count, half the frame
	localparam int nonGreen = `FRAME_WIDTH * `FRAME_HEIGHT / 2;
	localparam activity_t level1 = activity_t'(`ACT_LEVEL1 * nonGreen);
	localparam activity_t level2 = activity_t'(`ACT_LEVEL2 * nonGreen);
	localparam activity_t level3 = activity_t'(`ACT_LEVEL3 * nonGreen);
	localparam activity_t level4 = activity_t'(`ACT_LEVEL4 * nonGreen);

	activity_t activitySum;
	pixel_t thresholdNext;

	// Busier frames get a lower edge threshold
	always_comb begin
		if (activitySum < level1) thresholdNext = pixel_t'(`THRESH_0);
		else if (activitySum < level2) thresholdNext = pixel_t'(`THRESH_1);
		else if (activitySum < level3) thresholdNext = pixel_t'(`THRESH_2);
		else if (activitySum < level4) thresholdNext = pixel_t'(`THRESH_3);
		else thresholdNext = pixel_t'(`THRESH_4);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			activitySum <= '0;
			threshold <= '0;
			frameDone <= 1'b0;
		end else begin
			frameDone <= frameEnd;
			if (frameEnd) begin
				threshold <= thresholdNext;
				activitySum <= '0;
			end else if (strobe && gradSumValid) begin
				// Each held gradient is counted once, at the strobe that replaces it
				activitySum <= activitySum + activity_t'(gradSum);
			end
		end
	end

	frameDoneSingle: assert property (@(posedge clk) disable iff (reset)
		frameDone |=> !frameDone)
		else $error("frameDone high for more than one cycle");

endmodule

`default_nettype wire

/* verilog/demosaic_top.sv */
`timescale 1ns/10ps
`default_nettype none

module demosaic_top import demosaic_pkg::*; (
	input wire clk,
	input wire reset,
	input wire pixel_t data,
	input wire strobe,
	output pixel_t red,
	output pixel_t green,
	output pixel_t blue,
	output coord_t pixelX,
	output coord_t pixelY,
	output logic pixelValid,
	output pixel_t threshold,
	output logic frameDone
);

	pixel_t window00, window01, window02;
	pixel_t window10, window11, window12;
	pixel_t window20, window21, window22;
	coord_t centerX, centerY;
	logic centerValid;
	logic frameEnd;
	grad_t gradSum;
	logic gradSumValid;

	// Input side
	bayer_line_buffer lineBuffer (
		.clk, .reset, .strobe, .data,
		.window00, .window01, .window02,
		.window10, .window11, .window12,
		.window20, .window21, .window22
	);

	raster_tracker tracker (
		.clk, .reset, .strobe,
		.centerX, .centerY, .centerValid, .frameEnd
	);

	// Processing
	green_interpolator interpolator (
		.clk, .reset, .strobe,
		.window00, .window01, .window02,
		.window10, .window11, .window12,
		.window20, .window21, .window22,
		.centerX, .centerY, .centerValid,
		.red, .green, .blue,
		.pixelX, .pixelY, .pixelValid,
		.gradSum, .gradSumValid
	);

	// Output side
	activity_threshold activity (
		.clk, .reset, .strobe,
		.gradSum, .gradSumValid, .frameEnd,
		.threshold, .frameDone
	);

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset
);

	// 8 ns period
	localparam int halfPeriod = 4;
	localparam int resetCycles = 5;

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Release just after an edge so the DUT sees a clean synchronous reset
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* verification/demosaic_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "demosaic_macros.svh"

module demosaic_tb import demosaic_pkg::*; ();

	localparam int frameCount = 3;
	localparam int maxCyclesPerStrobe = 4;
	localparam int marginCycles = 200;
	localparam int timeoutCycles = frameCount * `FRAME_STROBES * maxCyclesPerStrobe
		+ marginCycles;
	localparam int framePixelTotal = `FRAME_WIDTH * `FRAME_HEIGHT;

	typedef struct packed {
		// Strobes seen when the pixel comes out
		int strobeTotal;
		coord_t x;
		coord_t y;
		pixel_t red;
		pixel_t green;
		pixel_t blue;
	} expPixel_t;

	logic clk;
	logic reset;
	pixel_t data;
	logic strobe;
	pixel_t red, green, blue;
	coord_t pixelX, pixelY;
	logic pixelValid;
	pixel_t threshold;
	logic frameDone;

	pixel_t frameMem [`FRAME_HEIGHT][`FRAME_WIDTH];
	expPixel_t pixelQueue [$];
	pixel_t thresholdQueue [$];
	pixel_t thresholdLog [frameCount];
	string testName [frameCount];

	expPixel_t expectedPixel;
	logic expectedReady;
	pixel_t expectedThreshold;
	logic thresholdReady;
	int strobesSeen;
	int framePixels;
	int donePixelCount;
	int doneCount;
	int errorCount;
	int passedTests;
	int failedTests;

	clock_gen clocks (
		.clk(clk),
		.reset(reset)
	);

	demosaic_top DUT (
		.clk(clk),
		.reset(reset),
		.data(data),
		.strobe(strobe),
		.red(red),
		.green(green),
		.blue(blue),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelValid(pixelValid),
		.threshold(threshold),
		.frameDone(frameDone)
	);

	function automatic pixel_t truncMean(input pixel_t p, input pixel_t q);
		int total;
		total = int'(p) + int'(q);
		return pixel_t'(total / 2);
	endfunction

	function automatic pixel_t absDistance(input pixel_t p, input pixel_t q);
		if (p > q) begin
			return pixel_t'(p - q);
		end
		return pixel_t'(q - p);
	endfunction

	// Frame 0 has a flat block for direction ties, frame 2 is low contrast
	task automatic buildFrame(input int kind);
		for (int y = 0; y < `FRAME_HEIGHT; y++) begin
			for (int x = 0; x < `FRAME_WIDTH; x++) begin
				if (kind == 0 && y >= 2 && y <= 5 && x >= 4 && x <= 11) begin
					frameMem[y][x] = 8'h80;
				end else if (kind == 2) begin
					frameMem[y][x] = pixel_t'($urandom_range(7, 0));
				end else begin
					frameMem[y][x] = pixel_t'($urandom);
				end
			end
		end
	endtask

	// Reference model straight from the boundary and site rules
	task automatic modelFrame(input int frameIndex);
		pixel_t left, right, up, down, center;
		pixel_t hAvg, vAvg, hGrad, vGrad, interp;
		activity_t activity;
		activity_t nonGreen;
		expPixel_t item;
		activity = '0;
		nonGreen = activity_t'(framePixelTotal / 2);
		for (int y = 0; y < `FRAME_HEIGHT; y++) begin
			for (int x = 0; x < `FRAME_WIDTH; x++) begin
				center = frameMem[y][x];
				left = '0;
				right = '0;
				up = '0;
				down = '0;
				if (x > 0) begin
					left = frameMem[y][x-1];
				end
				if (x < `FRAME_WIDTH - 1) begin
					right = frameMem[y][x+1];
				end
				if (y > 0) begin
					up = frameMem[y-1][x];
				end
				if (y < `FRAME_HEIGHT - 1) begin
					down = frameMem[y+1][x];
				end
				if (x == 0) hAvg = right;
				else if (x == `FRAME_WIDTH - 1) hAvg = left;
				else hAvg = truncMean(left, right);
				if (y == 0) vAvg = down;
				else if (y == `FRAME_HEIGHT - 1) vAvg = up;
				else vAvg = truncMean(up, down);
				hGrad = absDistance(left, right);
				vGrad = absDistance(up, down);
				if (hGrad > vGrad) interp = vAvg;
				else if (hGrad < vGrad) interp = hAvg;
				else interp = truncMean(hAvg, vAvg);
				// Count includes the strobe that registers the pixel
				item.strobeTotal = frameIndex * `FRAME_STROBES + y * `FRAME_WIDTH + x
					+ `CENTER_LAG + `INTERP_DEPTH + 1;
				item.x = coord_t'(x);
				item.y = coord_t'(y);
				if ((x + y) % 2 == 0) begin
					item.red = '0;
					item.green = center;
					item.blue = '0;
				end else begin
					activity = activity + activity_t'(hGrad) + activity_t'(vGrad);
					// Odd column on an even row is blue
					item.red = (x % 2 == 1) ? 8'd0 : center;
					item.green = interp;
					item.blue = (x % 2 == 1) ? center : 8'd0;
				end
				pixelQueue.push_back(item);
			end
		end
		if (activity < `ACT_LEVEL1 * nonGreen) thresholdQueue.push_back(`THRESH_0);
		else if (activity < `ACT_LEVEL2 * nonGreen) thresholdQueue.push_back(`THRESH_1);
		else if (activity < `ACT_LEVEL3 * nonGreen) thresholdQueue.push_back(`THRESH_2);
		else if (activity < `ACT_LEVEL4 * nonGreen) thresholdQueue.push_back(`THRESH_3);
		else thresholdQueue.push_back(`THRESH_4);
	endtask

	// Junk on data during idle cycles must not disturb anything
	task automatic driveSample(input pixel_t value, input int idleCycles);
		@(posedge clk);
		#1;
		data = value;
		strobe = 1'b1;
		for (int i = 0; i < idleCycles; i++) begin
			@(posedge clk);
			#1;
			strobe = 1'b0;
			data = pixel_t'($urandom);
		end
	endtask

	task automatic sendFrame(input logic withGaps);
		int idle;
		for (int n = 0; n < `FRAME_STROBES; n++) begin
			idle = withGaps ? int'($urandom_range(maxCyclesPerStrobe - 1, 0)) : 0;
			if (n < framePixelTotal) begin
				driveSample(frameMem[n / `FRAME_WIDTH][n % `FRAME_WIDTH], idle);
			end else begin
				driveSample('0, idle);
			end
		end
	endtask

	task automatic runFrames();
		for (int f = 0; f < frameCount; f++) begin
			buildFrame(f);
			modelFrame(f);
			sendFrame(f == 1);
		end
		@(posedge clk);
		#1;
		strobe = 1'b0;
	endtask

	task automatic reportTests();
		int errorsBefore;
		for (int f = 0; f < frameCount; f++) begin
			errorsBefore = errorCount;
			wait (doneCount > f);
			@(posedge clk);
			#1;
			if (errorCount == errorsBefore) passedTests++;
			else failedTests++;
			$display("Test %0d (%s): %0d pixels, threshold %0d, %0d errors",
				f, testName[f], donePixelCount, thresholdLog[f], errorCount - errorsBefore);
		end
	endtask

	task automatic reportPixelMismatch();
		string got;
		string want;
		errorCount++;
		if (!expectedReady) begin
			$display("Pixel output at %0t ns while no pixel was expected", $time);
		end else begin
			got = $sformatf("(%0d,%0d) rgb (%0d,%0d,%0d) after %0d strobes",
				pixelX, pixelY, red, green, blue, strobesSeen);
			want = $sformatf("(%0d,%0d) rgb (%0d,%0d,%0d) after %0d strobes",
				expectedPixel.x, expectedPixel.y, expectedPixel.red,
				expectedPixel.green, expectedPixel.blue, expectedPixel.strobeTotal);
			$display("Error: %0t ns: pixel %s, expected %s", $time, got, want);
		end
	endtask

	task automatic reportFrameMismatch();
		errorCount++;
		if (!thresholdReady) begin
			$display("Frame done at %0t ns while no frame was expected", $time);
		end else begin
			$display("Error: %0t ns: threshold %0d with %0d pixels, expected %0d with %0d",
				$time, threshold, donePixelCount, expectedThreshold, framePixelTotal);
		end
	endtask

	// Strobes accepted by the DUT since reset
	always @(posedge clk) begin
		if (!reset && strobe) begin
			strobesSeen <= strobesSeen + 1;
		end
	end

	// Expectations move on between edges, ready for the next sampling edge
	always @(negedge clk) begin
		if (!reset && pixelValid) begin
			expectedReady = (pixelQueue.size() > 0);
			if (expectedReady) begin
				expectedPixel = pixelQueue.pop_front();
			end
			framePixels++;
		end
		if (!reset && frameDone) begin
			thresholdReady = (thresholdQueue.size() > 0);
			if (thresholdReady) begin
				expectedThreshold = thresholdQueue.pop_front();
			end
			if (doneCount < frameCount) begin
				thresholdLog[doneCount] = threshold;
			end
			donePixelCount = framePixels;
			framePixels = 0;
			doneCount++;
		end
	end

	pixelMatchesModel: assert property (@(posedge clk) disable iff (reset)
		pixelValid |-> expectedReady && pixelX == expectedPixel.x
			&& pixelY == expectedPixel.y && red == expectedPixel.red
			&& green == expectedPixel.green && blue == expectedPixel.blue
			&& strobesSeen == expectedPixel.strobeTotal)
		else reportPixelMismatch();

	outputFollowsStrobe: assert property (@(posedge clk) disable iff (reset)
		pixelValid |-> $past(strobe))
		else begin
			errorCount++;
			$display("Pixel output at %0t ns did not follow a strobe", $time);
		end

	frameMatchesModel: assert property (@(posedge clk) disable iff (reset)
		frameDone |-> thresholdReady && threshold == expectedThreshold
			&& donePixelCount == framePixelTotal)
		else reportFrameMismatch();

	frameDoneOnce: assert property (@(posedge clk) disable iff (reset)
		frameDone |=> !frameDone)
		else begin
			errorCount++;
			$display("frameDone stayed high for two cycles at %0t ns", $time);
		end

	initial begin
		data = '0;
		strobe = 1'b0;
		expectedReady = 1'b0;
		thresholdReady = 1'b0;
		expectedPixel = '0;
		expectedThreshold = '0;
		strobesSeen = 0;
		framePixels = 0;
		donePixelCount = 0;
		doneCount = 0;
		errorCount = 0;
		passedTests = 0;
		failedTests = 0;
		testName[0] = "random frame with flat block";
		testName[1] = "random frame with strobe gaps";
		testName[2] = "low contrast frame";
		void'($urandom(32'hd494_494d));
		@(posedge clk);
		while (reset) @(posedge clk);
		fork
			runFrames();
			reportTests();
		join
		assert (pixelQueue.size() == 0)
		else begin
			errorCount++;
			$display("%0d expected pixels never came out", pixelQueue.size());
		end
		assert (doneCount == frameCount)
		else begin
			errorCount++;
			$display("Saw %0d frame ends instead of %0d", doneCount, frameCount);
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d",
			frameCount, passedTests, failedTests);
		if (errorCount == 0 && failedTests == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog sized for the longest gap on every strobe
	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("Timeout: frames did not finish within %0d clock cycles", timeoutCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/demosaic_pkg.sv
verilog/abs_diff.sv
verilog/bayer_line_buffer.sv
verilog/raster_tracker.sv
verilog/green_interpolator.sv
verilog/activity_threshold.sv
verilog/demosaic_top.sv
verification/clock_gen.sv
verification/demosaic_tb.sv

/* run.sh */
#!/bin/sh
# Build the demosaic testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module demosaic_tb -f vlog.f -o demosaic_sim \
	&& ./obj_dir/demosaic_sim > sim.log 2>&1

cat sim.log \
	&& grep -q "TEST PASSED" sim.log \
	&& ! grep -q "TEST FAILED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
